/* raystore_pkg.sv */
// ray store shared widths, requester indices, axis codes and ray vector layout
`default_nettype none

package raystore_pkg;

	localparam int FLOAT_W = 32;
	localparam int RAY_ID_W = 9;
	localparam int NODE_ID_W = 16;
	localparam int TRI_ID_W = 16;
	localparam int NUM_REQ = 4;
	localparam int RAM_LATENCY = 2;

	// requester slots, also bit positions of every request vector
	localparam int REQ_TRAV0 = 0;
	localparam int REQ_TRAV1 = 1;
	localparam int REQ_LCACHE = 2;
	localparam int REQ_LIST = 3;

	// split axis of a node, code 3 is illegal
	localparam logic [1:0] AXIS_X = 2'd0;
	localparam logic [1:0] AXIS_Y = 2'd1;
	localparam logic [1:0] AXIS_Z = 2'd2;

	// origin x,y,z then direction x,y,z
	localparam int NUM_LANES = 6;

	typedef union packed {
		logic [NUM_LANES*FLOAT_W-1:0] flat;
		logic [NUM_LANES-1:0][FLOAT_W-1:0] lane;
	} ray_vec_u;

endpackage

`default_nettype wire

/* raystore_blkram.sv */
// ray vector RAM: 512 words, two read ports, port a writes, two-cycle reads
`timescale 1ns/1ps
`default_nettype none

module raystore_blkram (
	input  logic clk,
	input  logic rst_n,
	input  logic [raystore_pkg::RAY_ID_W-1:0] address_a,
	input  logic [raystore_pkg::RAY_ID_W-1:0] address_b,
	input  raystore_pkg::ray_vec_u data_a,
	input  logic wren_a,
	output raystore_pkg::ray_vec_u q_a,
	output raystore_pkg::ray_vec_u q_b
);

	localparam int WORDS = 1 << raystore_pkg::RAY_ID_W;

	logic [$bits(raystore_pkg::ray_vec_u)-1:0] mem [WORDS];
	logic [raystore_pkg::RAY_ID_W-1:0] addr_a_q;
	logic [raystore_pkg::RAY_ID_W-1:0] addr_b_q;
	raystore_pkg::ray_vec_u data_a_q;
	logic wren_a_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wren_a_q <= 1'b0;
		else
			wren_a_q <= wren_a;
	end

	// input registers
	always_ff @(posedge clk) begin
		addr_a_q <= address_a;
		addr_b_q <= address_b;
		data_a_q <= data_a;
	end

	// a read that collides with the write sees the old word
	always_ff @(posedge clk) begin
		if (wren_a_q)
			mem[addr_a_q] <= data_a_q.flat;
		q_a.flat <= mem[addr_a_q];
		q_b.flat <= mem[addr_b_q];
	end

endmodule

`default_nettype wire

/* raystore_arb.sv */
// ray store arbiter: rotating pointer grants up to two RAM reads per cycle
`timescale 1ns/1ps
`default_nettype none

module raystore_arb (
	input  logic clk,
	input  logic rst_n,
	input  logic [raystore_pkg::NUM_REQ-1:0] req_valid,
	output logic [raystore_pkg::NUM_REQ-1:0] req_stall,
	input  logic [raystore_pkg::NUM_REQ-1:0] pipe_stall,
	output logic [raystore_pkg::NUM_REQ-1:0] pipe_valid,
	output logic [raystore_pkg::NUM_REQ-1:0] data_sel,
	output logic [1:0] mux_sel_a,
	output logic [1:0] mux_sel_b,
	input  logic raystore_we
);

	logic [1:0] rrp;
	logic [1:0] idx;
	logic [1:0] lo;
	logic [1:0] hi;
	logic [1:0] n_grant;
	logic [raystore_pkg::NUM_REQ-1:0] eligible;
	logic [raystore_pkg::NUM_REQ-1:0] choice;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rrp <= 2'd0;
		else
			rrp <= rrp + 2'd1;
	end

	assign eligible = req_valid & ~pipe_stall;

	// first two eligible, starting at the pointer
	always_comb begin
		choice = '0;
		n_grant = 2'd0;
		for (int i = 0; i < raystore_pkg::NUM_REQ; i++) begin
			idx = rrp + 2'(i);
			if (eligible[idx] && n_grant < 2'd2) begin
				choice[idx] = 1'b1;
				n_grant = n_grant + 2'd1;
			end
		end
	end

	// higher grant reads on port a, lower on port b
	always_comb begin
		lo = 2'd0;
		hi = 2'd0;
		for (int i = raystore_pkg::NUM_REQ - 1; i >= 0; i--) begin
			if (choice[i])
				lo = 2'(i);
		end
		for (int i = 0; i < raystore_pkg::NUM_REQ; i++) begin
			if (choice[i])
				hi = 2'(i);
		end
		mux_sel_a = hi;
		mux_sel_b = lo;
		data_sel = '0;
		if (n_grant == 2'd2)
			data_sel[lo] = 1'b1;
	end

	// a write owns port a, so the whole cycle goes to it
	assign pipe_valid = choice & ~{raystore_pkg::NUM_REQ{raystore_we}};
	assign req_stall = req_valid & ~pipe_valid;

	assert property (@(posedge clk) disable iff (!rst_n) $countones(pipe_valid) <= 2);
	assert property (@(posedge clk) disable iff (!rst_n)
		raystore_we |-> (pipe_valid == '0) && (req_stall == req_valid));

endmodule

`default_nettype wire

/* pipe_valid_stall.sv */
// side-data pipe matching RAM read latency, stalls upstream on FIFO credit
`timescale 1ns/1ps
`default_nettype none

module pipe_valid_stall #(
	parameter int WIDTH = 8,
	parameter int FIFO_K = 2
) (
	input  logic clk,
	input  logic rst_n,
	input  logic us_valid,
	input  logic [WIDTH-1:0] us_data,
	output logic us_stall,
	output logic ds_valid,
	output logic [WIDTH-1:0] ds_data,
	input  logic [FIFO_K:0] num_in_fifo
);

	localparam int DEPTH = raystore_pkg::RAM_LATENCY;
	localparam int CAP = 1 << FIFO_K;

	logic [DEPTH-1:0] stage_valid;
	logic [WIDTH-1:0] stage_data [DEPTH];
	logic [FIFO_K+1:0] in_flight;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			stage_valid <= '0;
		else
			stage_valid <= {stage_valid[DEPTH-2:0], us_valid};
	end

	always_ff @(posedge clk) begin
		stage_data[0] <= us_data;
		for (int i = 1; i < DEPTH; i++)
			stage_data[i] <= stage_data[i-1];
	end

	assign ds_valid = stage_valid[DEPTH-1];
	assign ds_data = stage_data[DEPTH-1];

	// items in the stages plus items already queued
	always_comb begin
		in_flight = {1'b0, num_in_fifo};
		for (int i = 0; i < DEPTH; i++)
			in_flight = in_flight + {{(FIFO_K+1){1'b0}}, stage_valid[i]};
	end

	// one entry per cycle at most, so stalling at capacity is enough
	assign us_stall = in_flight >= (FIFO_K+2)'(CAP);

	assert property (@(posedge clk) disable iff (!rst_n)
		ds_valid |-> num_in_fifo < (FIFO_K+1)'(CAP));

endmodule

`default_nettype wire

/* fifo.sv */
// small synchronous FIFO with occupancy count
`timescale 1ns/1ps
`default_nettype none

module fifo #(
	parameter int WIDTH = 8,
	parameter int K = 2
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [WIDTH-1:0] data_in,
	input  logic we,
	input  logic re,
	output logic full,
	output logic empty,
	output logic [WIDTH-1:0] data_out,
	output logic [K:0] num_in_fifo
);

	localparam int DEPTH = 1 << K;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [K-1:0] wr_ptr;
	logic [K-1:0] rd_ptr;
	logic [K:0] count;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (we)
				wr_ptr <= wr_ptr + 1'b1;
			if (re)
				rd_ptr <= rd_ptr + 1'b1;
			case ({we, re})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (we)
			mem[wr_ptr] <= data_in;
	end

	// head word shows as soon as it lands
	assign data_out = mem[rd_ptr];
	assign full = count == (K+1)'(DEPTH);
	assign empty = count == '0;
	assign num_in_fifo = count;

	assert property (@(posedge clk) disable iff (!rst_n) we |-> !full);
	assert property (@(posedge clk) disable iff (!rst_n) re |-> !empty);

endmodule

`default_nettype wire

/* raystore.sv */
// ray store top: four requesters share a dual-port ray vector RAM
`timescale 1ns/1ps
`default_nettype none

module raystore #(
	parameter int FIFO_K = 2
) (
	input  logic clk,
	input  logic rst_n,

	input  logic raystore_we,
	input  logic [raystore_pkg::RAY_ID_W-1:0] raystore_write_addr,
	input  raystore_pkg::ray_vec_u raystore_write_data,

	input  logic [raystore_pkg::RAY_ID_W-1:0] trav0_ray_id,
	input  logic [raystore_pkg::NODE_ID_W-1:0] trav0_node_id,
	input  logic [1:0] trav0_axis,
	input  logic trav0_valid,
	output logic trav0_stall,
	input  logic [raystore_pkg::RAY_ID_W-1:0] trav1_ray_id,
	input  logic [raystore_pkg::NODE_ID_W-1:0] trav1_node_id,
	input  logic [1:0] trav1_axis,
	input  logic trav1_valid,
	output logic trav1_stall,
	input  logic [raystore_pkg::RAY_ID_W-1:0] lcache_ray_id,
	input  logic [raystore_pkg::TRI_ID_W-1:0] lcache_tri_id,
	input  logic lcache_valid,
	output logic lcache_stall,
	input  logic [raystore_pkg::RAY_ID_W-1:0] list_ray_id,
	input  logic list_valid,
	output logic list_stall,

	output logic [raystore_pkg::RAY_ID_W-1:0] trav0_out_ray_id,
	output logic [raystore_pkg::NODE_ID_W-1:0] trav0_out_node_id,
	output logic [1:0] trav0_out_axis,
	output logic [raystore_pkg::FLOAT_W-1:0] trav0_out_origin,
	output logic [raystore_pkg::FLOAT_W-1:0] trav0_out_dir,
	output logic trav0_out_valid,
	input  logic trav0_out_stall,
	output logic [raystore_pkg::RAY_ID_W-1:0] trav1_out_ray_id,
	output logic [raystore_pkg::NODE_ID_W-1:0] trav1_out_node_id,
	output logic [1:0] trav1_out_axis,
	output logic [raystore_pkg::FLOAT_W-1:0] trav1_out_origin,
	output logic [raystore_pkg::FLOAT_W-1:0] trav1_out_dir,
	output logic trav1_out_valid,
	input  logic trav1_out_stall,
	output logic [raystore_pkg::RAY_ID_W-1:0] icache_ray_id,
	output logic [raystore_pkg::TRI_ID_W-1:0] icache_tri_id,
	output raystore_pkg::ray_vec_u icache_ray_vec,
	output logic icache_valid,
	input  logic icache_stall,
	output logic [raystore_pkg::RAY_ID_W-1:0] pcalc_ray_id,
	output raystore_pkg::ray_vec_u pcalc_ray_vec,
	output logic pcalc_valid,
	input  logic pcalc_stall
);

	localparam int RID_W = raystore_pkg::RAY_ID_W;
	localparam int VEC_W = $bits(raystore_pkg::ray_vec_u);
	localparam int TRAV_PIPE_W = RID_W + raystore_pkg::NODE_ID_W + 3;
	localparam int TRAV_OUT_W = RID_W + raystore_pkg::NODE_ID_W + 2 + 2 * raystore_pkg::FLOAT_W;
	localparam int LC_PIPE_W = RID_W + raystore_pkg::TRI_ID_W + 1;
	localparam int LC_OUT_W = RID_W + raystore_pkg::TRI_ID_W + VEC_W;
	localparam int LS_PIPE_W = RID_W + 1;
	localparam int LS_OUT_W = RID_W + VEC_W;

	logic [raystore_pkg::NUM_REQ-1:0] req_valid;
	logic [raystore_pkg::NUM_REQ-1:0] req_stall;
	logic [raystore_pkg::NUM_REQ-1:0] pipe_valid;
	logic [raystore_pkg::NUM_REQ-1:0] pipe_stall;
	logic [raystore_pkg::NUM_REQ-1:0] data_sel;
	logic [raystore_pkg::NUM_REQ-1:0][RID_W-1:0] req_ray_id;
	logic [1:0] mux_sel_a;
	logic [1:0] mux_sel_b;
	logic [RID_W-1:0] addr_a;
	logic [RID_W-1:0] addr_b;
	raystore_pkg::ray_vec_u q_a;
	raystore_pkg::ray_vec_u q_b;

	// traversal ports gathered so both share one lane path
	logic [1:0][raystore_pkg::NODE_ID_W-1:0] trav_node_id;
	logic [1:0][1:0] trav_axis;
	logic [1:0][TRAV_OUT_W-1:0] trav_out;
	logic [1:0] trav_out_valid;
	logic [1:0] trav_out_stall;

	// origin lane and the matching direction lane
	function automatic logic [2*raystore_pkg::FLOAT_W-1:0] axis_pair(
		input raystore_pkg::ray_vec_u vec,
		input logic [1:0] axis
	);
		int base;
		case (axis)
			raystore_pkg::AXIS_X: base = 0;
			raystore_pkg::AXIS_Y: base = 1;
			default: base = 2;
		endcase
		return {vec.lane[base], vec.lane[base + raystore_pkg::NUM_LANES / 2]};
	endfunction

	assign req_valid[raystore_pkg::REQ_TRAV0] = trav0_valid;
	assign req_valid[raystore_pkg::REQ_TRAV1] = trav1_valid;
	assign req_valid[raystore_pkg::REQ_LCACHE] = lcache_valid;
	assign req_valid[raystore_pkg::REQ_LIST] = list_valid;
	assign req_ray_id[raystore_pkg::REQ_TRAV0] = trav0_ray_id;
	assign req_ray_id[raystore_pkg::REQ_TRAV1] = trav1_ray_id;
	assign req_ray_id[raystore_pkg::REQ_LCACHE] = lcache_ray_id;
	assign req_ray_id[raystore_pkg::REQ_LIST] = list_ray_id;
	assign trav0_stall = req_stall[raystore_pkg::REQ_TRAV0];
	assign trav1_stall = req_stall[raystore_pkg::REQ_TRAV1];
	assign lcache_stall = req_stall[raystore_pkg::REQ_LCACHE];
	assign list_stall = req_stall[raystore_pkg::REQ_LIST];

	raystore_arb rsa (
		.clk,
		.rst_n,
		.req_valid,
		.req_stall,
		.pipe_stall,
		.pipe_valid,
		.data_sel,
		.mux_sel_a,
		.mux_sel_b,
		.raystore_we
	);

	// write address takes port a
	assign addr_a = raystore_we ? raystore_write_addr : req_ray_id[mux_sel_a];
	assign addr_b = req_ray_id[mux_sel_b];

	raystore_blkram rbram (
		.clk,
		.rst_n,
		.address_a(addr_a),
		.address_b(addr_b),
		.data_a(raystore_write_data),
		.wren_a(raystore_we),
		.q_a,
		.q_b
	);

	assign trav_node_id = {trav1_node_id, trav0_node_id};
	assign trav_axis = {trav1_axis, trav0_axis};
	assign trav_out_stall = {trav1_out_stall, trav0_out_stall};

	for (genvar t = 0; t < 2; t++) begin : g_trav
		localparam int R = (t == 0) ? raystore_pkg::REQ_TRAV0 : raystore_pkg::REQ_TRAV1;
		logic [TRAV_PIPE_W-1:0] p_out;
		logic [RID_W-1:0] p_ray_id;
		logic [raystore_pkg::NODE_ID_W-1:0] p_node_id;
		logic [1:0] p_axis;
		logic p_sel;
		logic p_valid;
		logic f_empty;
		logic [FIFO_K:0] nif;

		pipe_valid_stall #(.WIDTH(TRAV_PIPE_W), .FIFO_K(FIFO_K)) pvs (
			.clk,
			.rst_n,
			.us_valid(pipe_valid[R]),
			.us_data({req_ray_id[R], trav_node_id[t], trav_axis[t], data_sel[R]}),
			.us_stall(pipe_stall[R]),
			.ds_valid(p_valid),
			.ds_data(p_out),
			.num_in_fifo(nif)
		);
		assign {p_ray_id, p_node_id, p_axis, p_sel} = p_out;

		fifo #(.WIDTH(TRAV_OUT_W), .K(FIFO_K)) f (
			.clk,
			.rst_n,
			.data_in({p_ray_id, p_node_id, p_axis, axis_pair(p_sel ? q_b : q_a, p_axis)}),
			.we(p_valid),
			.re(~f_empty & ~trav_out_stall[t]),
			.full(),
			.empty(f_empty),
			.data_out(trav_out[t]),
			.num_in_fifo(nif)
		);
		assign trav_out_valid[t] = ~f_empty;

		assert property (@(posedge clk) disable iff (!rst_n)
			req_valid[R] && !req_stall[R] |-> trav_axis[t] <= raystore_pkg::AXIS_Z);
	end

	assign {trav0_out_ray_id, trav0_out_node_id, trav0_out_axis,
		trav0_out_origin, trav0_out_dir} = trav_out[0];
	assign {trav1_out_ray_id, trav1_out_node_id, trav1_out_axis,
		trav1_out_origin, trav1_out_dir} = trav_out[1];
	assign trav0_out_valid = trav_out_valid[0];
	assign trav1_out_valid = trav_out_valid[1];

	// leaf cache path, whole vector plus triangle
	logic [LC_PIPE_W-1:0] lc_pipe;
	logic [LC_OUT_W-1:0] lc_out;
	logic [RID_W-1:0] lc_ray_id;
	logic [raystore_pkg::TRI_ID_W-1:0] lc_tri_id;
	logic lc_sel;
	logic lc_valid;
	logic lc_empty;
	logic [FIFO_K:0] lc_nif;

	pipe_valid_stall #(.WIDTH(LC_PIPE_W), .FIFO_K(FIFO_K)) pvs_lc (
		.clk,
		.rst_n,
		.us_valid(pipe_valid[raystore_pkg::REQ_LCACHE]),
		.us_data({lcache_ray_id, lcache_tri_id, data_sel[raystore_pkg::REQ_LCACHE]}),
		.us_stall(pipe_stall[raystore_pkg::REQ_LCACHE]),
		.ds_valid(lc_valid),
		.ds_data(lc_pipe),
		.num_in_fifo(lc_nif)
	);
	assign {lc_ray_id, lc_tri_id, lc_sel} = lc_pipe;

	fifo #(.WIDTH(LC_OUT_W), .K(FIFO_K)) f_lc (
		.clk,
		.rst_n,
		.data_in({lc_ray_id, lc_tri_id, lc_sel ? q_b : q_a}),
		.we(lc_valid),
		.re(~lc_empty & ~icache_stall),
		.full(),
		.empty(lc_empty),
		.data_out(lc_out),
		.num_in_fifo(lc_nif)
	);
	assign {icache_ray_id, icache_tri_id, icache_ray_vec} = lc_out;
	assign icache_valid = ~lc_empty;

	// list path
	logic [LS_PIPE_W-1:0] ls_pipe;
	logic [LS_OUT_W-1:0] ls_out;
	logic ls_valid;
	logic ls_empty;
	logic [FIFO_K:0] ls_nif;

	pipe_valid_stall #(.WIDTH(LS_PIPE_W), .FIFO_K(FIFO_K)) pvs_ls (
		.clk,
		.rst_n,
		.us_valid(pipe_valid[raystore_pkg::REQ_LIST]),
		.us_data({list_ray_id, data_sel[raystore_pkg::REQ_LIST]}),
		.us_stall(pipe_stall[raystore_pkg::REQ_LIST]),
		.ds_valid(ls_valid),
		.ds_data(ls_pipe),
		.num_in_fifo(ls_nif)
	);

	fifo #(.WIDTH(LS_OUT_W), .K(FIFO_K)) f_ls (
		.clk,
		.rst_n,
		.data_in({ls_pipe[LS_PIPE_W-1:1], ls_pipe[0] ? q_b : q_a}),
		.we(ls_valid),
		.re(~ls_empty & ~pcalc_stall),
		.full(),
		.empty(ls_empty),
		.data_out(ls_out),
		.num_in_fifo(ls_nif)
	);
	assign {pcalc_ray_id, pcalc_ray_vec} = ls_out;
	assign pcalc_valid = ~ls_empty;

endmodule

`default_nettype wire

/* tb_clock.sv */
// testbench clock source, free-running with a 4 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 4
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

/* raystore_tb.sv */
// ray store testbench: table-driven requests checked against a memory model
`timescale 1ns/1ps
`default_nettype none

module raystore_tb;

	localparam int CLK_PERIOD = 4;
	localparam int NUM_REQ = raystore_pkg::NUM_REQ;
	localparam int RID_W = raystore_pkg::RAY_ID_W;
	localparam int NODE_W = raystore_pkg::NODE_ID_W;
	localparam int TRI_W = raystore_pkg::TRI_ID_W;
	localparam int FLOAT_W = raystore_pkg::FLOAT_W;
	localparam int NUM_LANES = raystore_pkg::NUM_LANES;
	localparam int VEC_W = $bits(raystore_pkg::ray_vec_u);
	localparam int WORD_W = 256;
	localparam int MAX_ROWS = 256;
	localparam int OP_IDLE = 0;
	localparam int OP_WRITE = 1;
	localparam int OP_REQ = 2;

	logic clk;
	logic rst_n = 1'b0;
	logic raystore_we = 1'b0;
	logic [RID_W-1:0] raystore_write_addr = '0;
	logic [VEC_W-1:0] raystore_write_data = '0;
	logic [NUM_REQ-1:0] req_valid = '0;
	logic [RID_W-1:0] req_ray [NUM_REQ] = '{default: '0};
	logic [NODE_W-1:0] req_node [NUM_REQ] = '{default: '0};
	logic [TRI_W-1:0] req_tri [NUM_REQ] = '{default: '0};
	logic [1:0] req_axis [NUM_REQ] = '{default: '0};
	logic [NUM_REQ-1:0] out_stall = '0;
	wire [NUM_REQ-1:0] req_stall;
	wire [NUM_REQ-1:0] resp_valid;

	logic [RID_W-1:0] trav0_out_ray_id;
	logic [NODE_W-1:0] trav0_out_node_id;
	logic [1:0] trav0_out_axis;
	logic [FLOAT_W-1:0] trav0_out_origin;
	logic [FLOAT_W-1:0] trav0_out_dir;
	logic [RID_W-1:0] trav1_out_ray_id;
	logic [NODE_W-1:0] trav1_out_node_id;
	logic [1:0] trav1_out_axis;
	logic [FLOAT_W-1:0] trav1_out_origin;
	logic [FLOAT_W-1:0] trav1_out_dir;
	logic [RID_W-1:0] icache_ray_id;
	logic [TRI_W-1:0] icache_tri_id;
	logic [VEC_W-1:0] icache_ray_vec;
	logic [RID_W-1:0] pcalc_ray_id;
	logic [VEC_W-1:0] pcalc_ray_vec;

	// stimulus table
	int tbl_op [MAX_ROWS];
	int tbl_tgt [MAX_ROWS];
	logic [RID_W-1:0] tbl_ray [MAX_ROWS];
	logic [NODE_W-1:0] tbl_node [MAX_ROWS];
	logic [TRI_W-1:0] tbl_tri [MAX_ROWS];
	logic [1:0] tbl_axis [MAX_ROWS];
	bit tbl_bp [MAX_ROWS];
	int n_rows = 0;
	int n_req_rows = 0;
	int release_ptr = 0;
	int scan_pos [NUM_REQ] = '{default: 0};

	// scoreboard, tag in the top two bits
	logic [VEC_W-1:0] model [1 << RID_W];
	logic [WORD_W+1:0] exp_q [$];
	bit took [NUM_REQ];
	bit held [NUM_REQ];
	logic [WORD_W-1:0] held_word [NUM_REQ];
	int accepted = 0;
	int quiet_run = 0;
	int stall_run [NUM_REQ] = '{default: 0};
	logic [31:0] seed = 32'haeec_a931;
	int row;

	tb_clock #(.PERIOD(CLK_PERIOD)) clk_gen (
		.clk
	);

	raystore #(.FIFO_K(2)) dut (
		.clk,
		.rst_n,
		.raystore_we,
		.raystore_write_addr,
		.raystore_write_data,
		.trav0_ray_id(req_ray[0]),
		.trav0_node_id(req_node[0]),
		.trav0_axis(req_axis[0]),
		.trav0_valid(req_valid[0]),
		.trav0_stall(req_stall[0]),
		.trav1_ray_id(req_ray[1]),
		.trav1_node_id(req_node[1]),
		.trav1_axis(req_axis[1]),
		.trav1_valid(req_valid[1]),
		.trav1_stall(req_stall[1]),
		.lcache_ray_id(req_ray[2]),
		.lcache_tri_id(req_tri[2]),
		.lcache_valid(req_valid[2]),
		.lcache_stall(req_stall[2]),
		.list_ray_id(req_ray[3]),
		.list_valid(req_valid[3]),
		.list_stall(req_stall[3]),
		.trav0_out_ray_id,
		.trav0_out_node_id,
		.trav0_out_axis,
		.trav0_out_origin,
		.trav0_out_dir,
		.trav0_out_valid(resp_valid[0]),
		.trav0_out_stall(out_stall[0]),
		.trav1_out_ray_id,
		.trav1_out_node_id,
		.trav1_out_axis,
		.trav1_out_origin,
		.trav1_out_dir,
		.trav1_out_valid(resp_valid[1]),
		.trav1_out_stall(out_stall[1]),
		.icache_ray_id,
		.icache_tri_id,
		.icache_ray_vec,
		.icache_valid(resp_valid[2]),
		.icache_stall(out_stall[2]),
		.pcalc_ray_id,
		.pcalc_ray_vec,
		.pcalc_valid(resp_valid[3]),
		.pcalc_stall(out_stall[3])
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int ray_of(input int k);
		return k * 61 + 3;
	endfunction

	task automatic fail_stop();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic value_error(input string msg);
		$display("ERROR at %0d ns: %s", $time, msg);
		fail_stop();
	endtask

	task automatic add_row(input int op, input int tgt, input int ray, input int node,
		input int tri_id, input int axis, input bit bp);
		tbl_op[n_rows] = op;
		tbl_tgt[n_rows] = tgt;
		tbl_ray[n_rows] = RID_W'(ray);
		tbl_node[n_rows] = NODE_W'(node);
		tbl_tri[n_rows] = TRI_W'(tri_id);
		tbl_axis[n_rows] = 2'(axis);
		tbl_bp[n_rows] = bp;
		if (op == OP_REQ)
			n_req_rows++;
		n_rows++;
	endtask

	task automatic build_table();
		int k;
		for (k = 0; k < 8; k++)
			add_row(OP_WRITE, 0, ray_of(k), 0, 0, 0, 1'b0);
		add_row(OP_IDLE, 0, 0, 0, 0, 0, 1'b0);
		add_row(OP_IDLE, 0, 0, 0, 0, 0, 1'b0);
		// whole-vector reads
		for (k = 0; k < 8; k++) begin
			add_row(OP_REQ, raystore_pkg::REQ_LCACHE, ray_of(k), 0, k * 257 + 1, 0, 1'b0);
			add_row(OP_REQ, raystore_pkg::REQ_LIST, ray_of(k), 0, 0, 0, 1'b0);
		end
		// one traversal request per axis code
		for (k = 0; k < 3; k++) begin
			add_row(OP_REQ, raystore_pkg::REQ_TRAV0, ray_of(k), 100 + k, 0, k, 1'b0);
			add_row(OP_REQ, raystore_pkg::REQ_TRAV1, ray_of(k + 3), 200 + k, 0, k, 1'b0);
		end
		for (k = 0; k < 12; k++)
			add_row(OP_IDLE, 0, 0, 0, 0, 0, 1'b0);
		// all four at once under random response stalls, with a write in between
		for (k = 0; k < 32; k++) begin
			if (k == 16)
				add_row(OP_WRITE, 0, ray_of(1), 0, 0, 0, 1'b1);
			add_row(OP_REQ, k % 4, ray_of((k * 3) % 8), 1000 + k, 7 * k, k % 3, 1'b1);
		end
		for (k = 0; k < 40; k++)
			add_row(OP_IDLE, 0, 0, 0, 0, 0, 1'b1);
		// all four at once, responses never stalled
		for (k = 0; k < 32; k++)
			add_row(OP_REQ, k % 4, ray_of((k * 5) % 8), 2000 + k, 11 * k, (k + 1) % 3, 1'b0);
		for (k = 0; k < 30; k++)
			add_row(OP_IDLE, 0, 0, 0, 0, 0, 1'b0);
	endtask

	// one clock of write port and response stall drive
	task automatic drive_cycle(input int r);
		logic [VEC_W-1:0] data;
		int l;
		data = '0;
		raystore_we <= tbl_op[r] == OP_WRITE;
		if (tbl_op[r] == OP_WRITE) begin
			for (l = 0; l < NUM_LANES; l++) begin
				seed = lcg_next(seed);
				data[l*FLOAT_W +: FLOAT_W] = seed;
			end
			raystore_write_addr <= tbl_ray[r];
			raystore_write_data <= data;
		end
		seed = lcg_next(seed);
		out_stall <= tbl_bp[r] ? (seed[31:28] & seed[23:20]) : 4'b0;
	endtask

	function automatic logic [WORD_W-1:0] expect_word(input int i);
		logic [VEC_W-1:0] vec;
		int ax;
		vec = model[req_ray[i]];
		ax = req_axis[i];
		if (i == raystore_pkg::REQ_LCACHE)
			return WORD_W'({req_ray[i], req_tri[i], vec});
		if (i == raystore_pkg::REQ_LIST)
			return WORD_W'({req_ray[i], vec});
		// origin lane ax, direction lane 3+ax
		return WORD_W'({req_ray[i], req_node[i], req_axis[i],
			vec[ax*FLOAT_W +: FLOAT_W], vec[(ax+3)*FLOAT_W +: FLOAT_W]});
	endfunction

	function automatic logic [WORD_W-1:0] got_word(input int i);
		case (i)
			raystore_pkg::REQ_TRAV0: return WORD_W'({trav0_out_ray_id, trav0_out_node_id,
				trav0_out_axis, trav0_out_origin, trav0_out_dir});
			raystore_pkg::REQ_TRAV1: return WORD_W'({trav1_out_ray_id, trav1_out_node_id,
				trav1_out_axis, trav1_out_origin, trav1_out_dir});
			raystore_pkg::REQ_LCACHE: return WORD_W'({icache_ray_id, icache_tri_id, icache_ray_vec});
			default: return WORD_W'({pcalc_ray_id, pcalc_ray_vec});
		endcase
	endfunction

	task automatic check_response(input int i);
		logic [WORD_W-1:0] got;
		int j;
		got = got_word(i);
		if (held[i])
			assert (resp_valid[i] && got === held_word[i])
				else value_error($sformatf("port %0d changed a stalled response", i));
		held[i] = resp_valid[i] && out_stall[i];
		held_word[i] = got;
		if (resp_valid[i] && !out_stall[i]) begin
			j = 0;
			while (j < exp_q.size() && exp_q[j][WORD_W +: 2] != 2'(i))
				j++;
			if (j == exp_q.size()) begin
				$display("port %0d returned a response that was never requested", i);
				fail_stop();
			end else begin
				assert (got === exp_q[j][WORD_W-1:0])
					else value_error($sformatf("port %0d got %h, expected %h",
						i, got, exp_q[j][WORD_W-1:0]));
				exp_q.delete(j);
			end
		end
	endtask

	// first quiet cycle may still drain a full FIFO
	task automatic track_fairness();
		int i;
		if (&req_valid && !raystore_we && out_stall == '0)
			quiet_run++;
		else
			quiet_run = 0;
		for (i = 0; i < NUM_REQ; i++) begin
			if (quiet_run > 1 && req_stall[i])
				stall_run[i]++;
			else
				stall_run[i] = 0;
			assert (stall_run[i] < 4)
				else value_error($sformatf("port %0d stalled 4 cycles in a row", i));
		end
	endtask

	// requester side, one held request per port
	always @(posedge clk) begin
		for (int i = 0; i < NUM_REQ; i++) begin
			if (!req_valid[i] || took[i]) begin
				while (scan_pos[i] < release_ptr &&
					!(tbl_op[scan_pos[i]] == OP_REQ && tbl_tgt[scan_pos[i]] == i))
					scan_pos[i]++;
				if (scan_pos[i] < release_ptr) begin
					req_ray[i] <= tbl_ray[scan_pos[i]];
					req_node[i] <= tbl_node[scan_pos[i]];
					req_tri[i] <= tbl_tri[scan_pos[i]];
					req_axis[i] <= tbl_axis[scan_pos[i]];
					req_valid[i] <= 1'b1;
					scan_pos[i]++;
				end else begin
					req_valid[i] <= 1'b0;
				end
			end
		end
	end

	// sampled mid-cycle, so this is what the next rising edge sees
	always @(negedge clk) begin
		if (rst_n) begin
			if (raystore_we) begin
				model[raystore_write_addr] = raystore_write_data;
				assert (req_stall == req_valid)
					else value_error("request not stalled during a write");
			end
			assert ((req_stall & ~req_valid) == '0)
				else value_error("stall high on a port with no request");
			for (int i = 0; i < NUM_REQ; i++) begin
				took[i] = req_valid[i] && !req_stall[i];
				if (took[i]) begin
					exp_q.push_back({2'(i), expect_word(i)});
					accepted++;
				end
				check_response(i);
			end
			track_fairness();
		end
	end

	initial begin
		build_table();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (resp_valid == '0 && req_stall == '0)
			else value_error("response valid or request stall high after reset");
		// request rows are released at once, other rows take a clock each
		for (row = 0; row < n_rows; row++) begin
			if (tbl_op[row] != OP_REQ) begin
				@(posedge clk);
				drive_cycle(row);
			end
			release_ptr <= row + 1;
		end
		@(posedge clk);
		raystore_we <= 1'b0;
		out_stall <= '0;
		while (accepted < n_req_rows || exp_q.size() != 0)
			@(posedge clk);
		repeat (8) @(posedge clk);
		if (exp_q.size() == 0 && resp_valid == '0 && req_valid == '0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("responses or requests still outstanding at end of run");
			fail_stop();
		end
	end

	initial begin
		#1;
		#(n_rows * 40 * CLK_PERIOD);
		$display("watchdog expired, the run did not finish in time");
		fail_stop();
	end

endmodule

`default_nettype wire

/* raystore.f */
raystore_pkg.sv
raystore_blkram.sv
raystore_arb.sv
pipe_valid_stall.sv
fifo.sv
raystore.sv
tb_clock.sv
raystore_tb.sv
